// File: logic/blank_delay.sv
// blanking delay
// carries rgb and both blanking bits through blank_dly pixels
// and forces black while either blank is active

`timescale 1ns/1ps

module blank_delay import colmix_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic pxl_cen,
    input  logic preLHBL,
    input  logic preLVBL,
    input  rgb_t rgb_in,
    output logic LHBL,
    output logic LVBL,
    output rgb_t rgb_out
);

    logic [blank_dly-1:0] hb_sr;
    logic [blank_dly-1:0] vb_sr;
    rgb_t                 rgb_sr [blank_dly];

    // blanking shift starts blanked after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            hb_sr <= '0;
            vb_sr <= '0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[blank_dly-2:0], preLHBL};
            vb_sr <= {vb_sr[blank_dly-2:0], preLVBL};
        end
    end

    // colour shift of the same depth
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb_sr[0] <= rgb_in;
            for (int i = 1; i < blank_dly; i++) begin
                rgb_sr[i] <= rgb_sr[i-1];
            end
        end
    end

    assign LHBL    = hb_sr[blank_dly-1];
    assign LVBL    = vb_sr[blank_dly-1];
    assign rgb_out = (LHBL && LVBL) ? rgb_sr[blank_dly-1] : '0;

    // blanking inputs must be clean on every pixel
    a_blank_known: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |-> !$isunknown({preLHBL, preLVBL})
    ) else $error("blank_delay: unknown blanking input on pxl_cen");

endmodule

// File: logic/colmix.sv
// colour mixer top
// layer select, palette lookup with cpu access, 5-5-5 unpack
// and blanking delay, all paced by the pixel enable

`timescale 1ns/1ps

module colmix import colmix_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic              preLHBL,
    input  logic              preLVBL,
    // cpu interface
    input  logic              pal_cs,
    input  logic [pal_aw-1:0] cpu_addr,
    input  logic [15:0]       cpu_dout,
    input  logic [1:0]        dswn,
    output logic [15:0]       cpu_din,
    // layer inputs
    input  logic [pal_aw-1:0] tmap_addr,
    input  obj_pxl_t          obj_pxl,
    input  road_in_t          road,
    // video out
    output logic [4:0]        red,
    output logic [4:0]        green,
    output logic [4:0]        blue,
    output logic              LHBL,
    output logic              LVBL
);

    logic [1:0]        we;
    logic [pal_aw-1:0] pal_addr;
    pal_word_t         pal_out;
    rgb_t              rgb_unpk;
    rgb_t              rgb_q;
    rgb_t              rgb_out;

    // strobes are active low, gated by the chip select
    assign we = ~dswn & {2{pal_cs}};

    layer_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .obj       (obj_pxl),
        .road      (road),
        .tmap_addr (tmap_addr),
        .pal_addr  (pal_addr)
    );

    pal_ram u_ram (
        .clk       (clk),
        .cpu_we    (we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_dout),
        .cpu_rdata (cpu_din),
        .vid_addr  (pal_addr),
        .vid_data  (pal_out)
    );

    // nibble gives the top four bits, bits 12-14 the lsb
    always_comb begin
        rgb_unpk.red   = {pal_out.r_hi, pal_out.r_lo};
        rgb_unpk.green = {pal_out.g_hi, pal_out.g_lo};
        rgb_unpk.blue  = {pal_out.b_hi, pal_out.b_lo};
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb_q <= rgb_unpk;
        end
    end

    blank_delay u_blank (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .preLHBL (preLHBL),
        .preLVBL (preLVBL),
        .rgb_in  (rgb_q),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .rgb_out (rgb_out)
    );

    assign red   = rgb_out.red;
    assign green = rgb_out.green;
    assign blue  = rgb_out.blue;

    // palette read needs a spare clk between pixels
    a_cen_gap: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen
    ) else $error("colmix: pxl_cen high on back to back clocks");

endmodule

// File: logic/colmix_pkg.sv
// colour mixer shared types and constants
// palette word layout, layer pixel bundles and 5-5-5 rgb

package colmix_pkg;

    // palette ram is 2K words
    localparam int pal_aw = 11;

    // pixels of delay through the blanking stage
    localparam int blank_dly = 3;

    // sprite pixel from the object layer
    typedef struct packed {
        logic       rsv_hi;     // bit 12
        logic [1:0] prio;       // bits 11:10
        logic [5:0] rsv_mid;    // bits 9:4, not used by the mux
        logic [3:0] color;      // bits 3:0
    } obj_pxl_t;

    // road generator pixel plus the fix layer flag
    typedef struct packed {
        logic [7:0] rd_pxl;     // road palette pixel
        // road control, board bits 4:3
        logic [1:0] rc;
        logic       sa;
        logic       sb;
        logic       fix;        // fix layer is opaque here
    } road_in_t;

    // one palette ram entry
    // nibbles hold the top four bits of each colour
    typedef struct packed {
        logic       spare;      // bit 15, shadow flag on the board
        logic       b_lo;       // bit 14
        logic       g_lo;       // bit 13
        logic       r_lo;       // bit 12
        logic [3:0] b_hi;       // bits 11:8
        logic [3:0] g_hi;       // bits 7:4
        logic [3:0] r_hi;       // bits 3:0
    } pal_word_t;

    // 5 bits per colour, red on top
    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

endpackage

// File: logic/layer_mux.sv
// road / tile layer select
// latches the sprite pixel, builds the road palette index and
// picks road or tile map as the palette address

`timescale 1ns/1ps

module layer_mux import colmix_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  obj_pxl_t          obj,
    input  road_in_t          road,
    input  logic [pal_aw-1:0] tmap_addr,
    output logic [pal_aw-1:0] pal_addr
);

    obj_pxl_t          objl;
    logic [pal_aw-1:0] rd_idx;
    logic              muxsel;

    // sprite pixel is one pixel ahead of road and tiles
    always_ff @(posedge clk) begin
        if (rst) begin
            objl <= '0;
        end else if (pxl_cen) begin
            objl <= obj;
        end
    end

    // road palette index
    always_comb begin
        rd_idx[3:0] = road.rd_pxl[3:0];
        case (road.rc)
            2'd0,
            2'd1:    rd_idx[5:4] = 2'b11;
            2'd2:    rd_idx[5:4] = {1'b0, road.rd_pxl[4]};
            default: rd_idx[5:4] = road.rd_pxl[5:4];
        endcase
        // upper bank follows the top control bit
        rd_idx[10:6] = {5{road.rc[1]}};
    end

    // priority equation
    // transparent sprite lets road through, unless rc bit 3 is set
    // and one of the road layers is active
    // prio 2 colour 5 is a road window sprite
    always_comb begin
        muxsel = !road.fix && (
            (objl.color == 4'h0 && (!road.rc[0] || (!road.sa && !road.sb))) ||
            (objl.prio == 2'd2 && objl.color == 4'h5));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pal_addr <= '0;
        end else if (pxl_cen) begin
            pal_addr <= muxsel ? rd_idx : tmap_addr;
        end
    end

    // layer inputs must be driven whenever a pixel is taken
    a_in_known: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |-> !$isunknown({obj, road, tmap_addr})
    ) else $error("layer_mux: unknown layer input on pxl_cen");

endmodule

// File: logic/pal_ram.sv
// palette RAM, 2K x 16
// port a is the cpu side with byte writes and read-back
// port b is a read-only video lookup

`timescale 1ns/1ps

module pal_ram import colmix_pkg::*; (
    input  logic              clk,
    // cpu port
    input  logic [1:0]        cpu_we,
    input  logic [pal_aw-1:0] cpu_addr,
    input  logic [15:0]       cpu_wdata,
    output logic [15:0]       cpu_rdata,
    // video port
    input  logic [pal_aw-1:0] vid_addr,
    output pal_word_t         vid_data
);

    logic [15:0] mem [0:(2**pal_aw)-1];

    // byte lanes, bit 1 is the upper byte
    always_ff @(posedge clk) begin
        if (cpu_we[0]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        if (cpu_we[1]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
    end

    // cpu read-back, old data on a write cycle
    always_ff @(posedge clk) begin
        cpu_rdata <= mem[cpu_addr];
    end

    // video read every clk
    // the pixel enable is slow enough for this to settle
    always_ff @(posedge clk) begin
        vid_data <= pal_word_t'(mem[vid_addr]);
    end

    // write strobes must be clean once the bus is running
    a_we_known: assert property (
        @(posedge clk) 1'b1 |=> !$isunknown(cpu_we)
    ) else $error("pal_ram: cpu_we unknown");

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the colour mixer testbench with Verilator
# exit status is 0 only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

top=colmix_tb
mdir=obj_dir

if ! command -v verilator > /dev/null; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module "$top" --Mdir "$mdir" -o "sim_$top" -f tb.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$("./$mdir/sim_$top")
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/colmix_tb.sv
// testbench for the colour mixer
// replays a trace of palette cpu accesses and pixels, checks
// cpu read-back, rgb and blanking against the trace columns

`timescale 1ns/1ps

module colmix_tb import colmix_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              pxl_cen;
    logic              pre_lhbl;
    logic              pre_lvbl;
    logic              pal_cs;
    logic [pal_aw-1:0] cpu_addr;
    logic [15:0]       cpu_dout;
    logic [1:0]        dswn;
    logic [15:0]       cpu_din;
    logic [pal_aw-1:0] tmap_addr;
    obj_pxl_t          obj_pxl;
    road_in_t          road;
    logic [4:0]        red;
    logic [4:0]        green;
    logic [4:0]        blue;
    logic              lhbl;
    logic              lvbl;

    // pending output values, keyed by the enable count they are due on
    typedef struct packed {
        int   due;
        rgb_t rgb;
    } rgb_item_t;

    typedef struct packed {
        int   due;
        logic lh;
        logic lv;
    } blank_item_t;

    rgb_item_t   rgb_exp [$];
    blank_item_t blank_exp [$];

    int n_cen    = 0;
    int n_checks = 0;
    int n_pixels = 0;
    int err_cnt  = 0;
    int fail_cnt = 0;

    colmix uut (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .preLHBL   (pre_lhbl),
        .preLVBL   (pre_lvbl),
        .pal_cs    (pal_cs),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .dswn      (dswn),
        .cpu_din   (cpu_din),
        .tmap_addr (tmap_addr),
        .obj_pxl   (obj_pxl),
        .road      (road),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .LHBL      (lhbl),
        .LVBL      (lvbl)
    );

    // 40 ns pixel clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // compare whatever falls due on the current enable
    task automatic compare_due();
        rgb_item_t   ri;
        blank_item_t bi;
        while (rgb_exp.size() > 0 && rgb_exp[0].due == n_cen) begin
            ri = rgb_exp.pop_front();
            check("red", 32'(red), 32'(ri.rgb.red));
            check("green", 32'(green), 32'(ri.rgb.green));
            check("blue", 32'(blue), 32'(ri.rgb.blue));
        end
        while (blank_exp.size() > 0 && blank_exp[0].due == n_cen) begin
            bi = blank_exp.pop_front();
            check("LHBL", 32'(lhbl), 32'(bi.lh));
            check("LVBL", 32'(lvbl), 32'(bi.lv));
        end
    endtask

    // one pixel, enable on the second edge, outputs read at the negedge
    task automatic drive_pixel(input obj_pxl_t o, input road_in_t r,
                               input logic [pal_aw-1:0] t, input logic hb, input logic vb);
        @(posedge clk);
        pxl_cen   <= 1'b1;
        obj_pxl   <= o;
        road      <= r;
        tmap_addr <= t;
        pre_lhbl  <= hb;
        pre_lvbl  <= vb;
        @(posedge clk);
        pxl_cen <= 1'b0;
        @(negedge clk);
        n_cen++;
        compare_due();
    endtask

    // strobes released on the write edge itself
    task automatic cpu_write(input logic [pal_aw-1:0] a, input logic [15:0] d,
                             input logic [1:0] s, input logic cs);
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= a;
        cpu_dout <= d;
        dswn     <= s;
        @(posedge clk);
        pal_cs <= 1'b0;
        dswn   <= 2'b11;
    endtask

    // read data shows one clk after the address
    task automatic cpu_read_check(input logic [pal_aw-1:0] a, input logic [15:0] exp);
        @(posedge clk);
        cpu_addr <= a;
        @(posedge clk);
        @(negedge clk);
        check("cpu_din", 32'(cpu_din), 32'(exp));
    endtask

    task automatic run_trace_line(input string line);
        logic [31:0] f [14];
        int          nf;
        byte         kind;
        obj_pxl_t    o;
        road_in_t    r;
        rgb_item_t   ri;
        blank_item_t bi;
        kind = line.getc(0);
        if (kind == "W") begin
            nf = $sscanf(line, "W %h %h %h %h", f[0], f[1], f[2], f[3]);
            if (nf != 4) begin
                fail_cnt++;
                $display("malformed write line in trace: %s", line);
            end else begin
                cpu_write(f[0][pal_aw-1:0], f[1][15:0], f[2][1:0], f[3][0]);
            end
        end else if (kind == "R") begin
            nf = $sscanf(line, "R %h %h", f[0], f[1]);
            if (nf != 2) begin
                fail_cnt++;
                $display("malformed read line in trace: %s", line);
            end else begin
                cpu_read_check(f[0][pal_aw-1:0], f[1][15:0]);
            end
        end else if (kind == "P") begin
            nf = $sscanf(line, "P %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                         f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (nf != 14) begin
                fail_cnt++;
                $display("malformed pixel line in trace: %s", line);
            end else begin
                o        = f[0][12:0];
                r.rd_pxl = f[1][7:0];
                r.rc     = f[2][1:0];
                r.sa     = f[3][0];
                r.sb     = f[4][0];
                r.fix    = f[5][0];
                drive_pixel(o, r, f[6][pal_aw-1:0], f[7][0], f[8][0]);
                n_pixels++;
                // rgb four enables on, blanking two
                ri.due       = n_cen + 4;
                ri.rgb.red   = f[9][4:0];
                ri.rgb.green = f[10][4:0];
                ri.rgb.blue  = f[11][4:0];
                rgb_exp.push_back(ri);
                bi.due = n_cen + 2;
                bi.lh  = f[12][0];
                bi.lv  = f[13][0];
                blank_exp.push_back(bi);
            end
        end else begin
            fail_cnt++;
            $display("unknown record type in trace: %s", line);
        end
    endtask

    initial begin : main
        int       fd;
        int       nl;
        int       guard;
        string    line;
        obj_pxl_t idle_obj;
        road_in_t idle_road;
        rst       <= 1'b1;
        pxl_cen   <= 1'b0;
        pre_lhbl  <= 1'b0;
        pre_lvbl  <= 1'b0;
        pal_cs    <= 1'b0;
        cpu_addr  <= '0;
        cpu_dout  <= '0;
        dswn      <= 2'b11;
        tmap_addr <= '0;
        obj_pxl   <= '0;
        road      <= '0;
        idle_obj  = '0;
        idle_road = '0;
        idle_road.fix = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // blanked and black straight out of reset
        check("LHBL", 32'(lhbl), 32'd0);
        check("LVBL", 32'(lvbl), 32'd0);
        check("red", 32'(red), 32'd0);
        check("green", 32'(green), 32'd0);
        check("blue", 32'(blue), 32'd0);
        fd = $fopen("sim/colmix_trace.txt", "r");
        if (fd == 0) begin
            fail_cnt++;
            $display("could not open the trace file sim/colmix_trace.txt");
        end else begin
            nl = 0;
            while (!$feof(fd) && nl < 1000) begin
                line = "";
                void'($fgets(line, fd));
                nl++;
                if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    run_trace_line(line);
                end
            end
            if (!$feof(fd)) begin
                fail_cnt++;
                $display("trace reader gave up after %0d lines", nl);
            end
            $fclose(fd);
        end
        if (n_pixels == 0) begin
            fail_cnt++;
            $display("the trace held no pixel lines");
        end
        // drain with blanked tile pixels
        guard = 0;
        while ((rgb_exp.size() > 0 || blank_exp.size() > 0) && guard < 16) begin
            drive_pixel(idle_obj, idle_road, '0, 1'b0, 1'b0);
            guard++;
        end
        if (rgb_exp.size() > 0 || blank_exp.size() > 0) begin
            fail_cnt++;
            $display("timeout: expected pixels still pending after %0d idle pixels", guard);
        end
        $display("checks %0d, value errors %0d, other failures %0d",
                 n_checks, err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim/colmix_trace.txt
# W addr data dswn cs | R addr expected_data | all hex, dswn bit 1 is the upper strobe
# P obj rd_pxl rc sa sb fix tmap hb vb | exp red green blue | exp lhbl lvbl
#
# palette entries used by the pixels further down
W 000 0000 0 1
W 123 7A5C 0 1
W 2AB 9F30 0 1
W 037 2468 0 1
W 03A 5137 0 1
W 7D9 6EDB 0 1
W 7E6 1FFF 0 1
W 055 0481 0 1
R 000 0000
R 123 7A5C
R 2AB 9F30
R 037 2468
R 03A 5137
R 7D9 6EDB
R 7E6 1FFF
R 055 0481
# byte lanes, whole word then upper only then lower only
W 400 1234 0 1
R 400 1234
W 400 ABCD 1 1
R 400 AB34
W 400 5678 2 1
R 400 AB78
# chip select low, nothing lands
W 400 FFFF 0 0
R 400 AB78
W 7FF 0000 0 1
W 7FF C3A5 1 1
R 7FF C300
W 7FF 005A 3 1
R 7FF C300
W 7FF 1111 2 0
R 7FF C300
W 7FF 0011 2 1
R 7FF C311
R 123 7A5C
#
# obj is latched a pixel early: a line's rgb uses the obj of the line above
# output blanks lead rgb by two pixels, so rgb reads zero when
# the blank columns two lines further down are low
#
# blanked start, then tile pixels
P 0000 00 0 0 0 1 000 0 0 00 00 00 0 0
P 0000 00 0 0 0 1 000 0 0 00 00 00 0 0
P 0000 00 0 0 0 1 123 1 0 19 0B 15 1 0
P 0000 00 0 0 0 1 123 1 1 19 0B 15 1 1
P 0000 00 0 0 0 1 123 1 1 19 0B 15 1 1
P 0003 07 0 1 1 1 2AB 1 1 01 06 1E 1 1
# opaque sprite, then transparent sprite over road rc 0
P 0000 07 0 1 1 0 123 1 1 19 0B 15 1 1
P 0000 07 0 1 1 0 123 1 1 10 0D 08 1 1
# rc 1 needs sa and sb both low
P 0800 2A 1 1 0 0 055 1 1 02 10 08 1 1
P 0000 2A 1 0 0 0 055 1 1 0F 06 03 1 1
P 0000 2A 1 0 1 0 055 1 1 02 10 08 1 1
# rc 2 and rc 3 banks, prio 2 colour 5 window
P 0805 19 2 1 1 0 123 1 1 16 1B 1D 1 1
P 0805 26 3 1 1 0 123 1 1 1F 1E 1E 1 1
P 0805 26 3 1 1 1 2AB 1 1 01 06 1E 1 1
P 0C05 39 2 0 0 0 400 1 1 16 1B 1D 1 1
P 0405 19 3 1 1 0 400 1 1 10 0F 16 1 1
P 13F3 37 1 0 0 0 123 1 1 00 00 00 1 1
P 0000 37 1 0 0 0 400 1 1 00 00 00 1 1
# horizontal blank pulse
P 0000 07 0 0 0 0 123 0 1 10 0D 08 0 1
P 0000 07 0 0 0 0 123 0 1 10 0D 08 0 1
P 0000 00 0 0 0 1 2AB 1 1 00 00 00 1 1
P 0000 00 0 0 0 1 055 1 1 02 10 08 1 1
# vertical blank pulse then full blank
P 0000 00 0 0 0 1 123 1 0 19 0B 15 1 0
P 0000 00 0 0 0 1 123 1 1 00 00 00 1 1
P 0000 00 0 0 0 1 400 1 1 00 00 00 1 1
P 0000 00 0 0 0 1 000 0 0 00 00 00 0 0
P 0000 00 0 0 0 1 000 0 0 00 00 00 0 0

// File: tb.f
logic/colmix_pkg.sv
logic/pal_ram.sv
logic/layer_mux.sv
logic/blank_delay.sv
logic/colmix.sv
sim/colmix_tb.sv
